/* sd_spi_ctrl.f */
+incdir+include
source/sd_spi_pkg.sv
source/sd_reg_decode.sv
source/sd_spi_shifter.sv
source/sd_crc.sv
source/sd_readback.sv
source/sd_spi_ctrl.sv
tb/sd_spi_ctrl_assertions.sv
tb/sd_spi_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SD SPI controller testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sd_spi_ctrl_tb \
  -f sd_spi_ctrl.f -o sd_spi_ctrl_sim

./obj_dir/sd_spi_ctrl_sim

/* tb/sd_spi_ctrl_tb.sv */
/*
 * SD SPI controller testbench: card model, register bus stimulus,
 * CRC reference models and result checks.
 */
`timescale 1ns/100ps
`default_nettype none
`include "sd_spi_settings.svh"

module sd_spi_ctrl_tb
  import sd_spi_pkg::*;
();

  // 40 slow transfers of 1090 cycles with a margin of 2, rounded up.
  localparam int timeout_cycles = 100000;

  logic        clk;
  logic        rst;
  logic        stb;
  logic        we;
  reg_addr_t   addr;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        ack;
  logic        ss_n;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic        wr_protect;
  spi_byte_t   card_tx;
  spi_byte_t   card_rx;
  int          rise_count;
  int          cycles;
  logic [31:0] rd_value;
  spi_byte_t   tx_byte;
  spi_byte_t   resp_byte;

  sd_spi_ctrl dut_i (
    .clk, .rst, .stb, .we, .addr, .data_in, .data_out, .ack,
    .ss_n, .sclk, .mosi, .miso, .wr_protect
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // card side, SPI mode 0, msb first.
  assign miso = card_tx[7];

  always @(posedge sclk) begin
    card_rx = {card_rx[6:0], mosi};
    rise_count = rise_count + 1;
  end

  always @(negedge sclk) begin
    #1;
    card_tx = {card_tx[6:0], 1'b1};
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: no result after %0d clock cycles", cycles);
      $display("Simulation failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  function automatic crc7_t crc7_ref(input crc7_t seed, input spi_byte_t bytes[$]);
    crc7_t c;
    logic  fb;
    c = seed;
    foreach (bytes[i]) begin
      for (int b = 7; b >= 0; b--) begin
        fb = c[6] ^ bytes[i][b];
        c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      end
    end
    return c;
  endfunction

  function automatic crc16_t crc16_ref(input crc16_t seed, input spi_byte_t bytes[$]);
    crc16_t c;
    logic   fb;
    c = seed;
    foreach (bytes[i]) begin
      for (int b = 7; b >= 0; b--) begin
        fb = c[15] ^ bytes[i][b];
        c = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
      end
    end
    return c;
  endfunction

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "byte mismatch");
    end
  endtask

  task automatic check_crc7(input string name, input crc7_t exp, input crc7_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "crc7 mismatch");
    end
  endtask

  task automatic check_crc16(input string name, input crc16_t exp, input crc16_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "crc16 mismatch");
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "ack mismatch");
    end
  endtask

  task automatic check_edges(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error: %s expected %0d sclk edges actual %0d", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "edge count mismatch");
    end
  endtask

  task automatic bus_write(input reg_addr_t slot, input logic [31:0] value);
    stb = 1'b1;
    we = 1'b1;
    addr = slot;
    data_in = value;
    @(posedge clk);
    #1;
    stb = 1'b0;
    we = 1'b0;
  endtask

  // data_out is sampled mid cycle, well away from the clock edge.
  task automatic bus_read(input reg_addr_t slot, output logic [31:0] value);
    stb = 1'b1;
    we = 1'b0;
    addr = slot;
    #1;
    value = data_out;
    check_ack("bus ack", 1'b1, ack);
    @(posedge clk);
    #1;
    stb = 1'b0;
  endtask

  task automatic start_byte(input spi_byte_t tx, input spi_byte_t resp);
    card_tx = resp;
    card_rx = '0;
    rise_count = 0;
    bus_write(data, {24'h0, tx});
  endtask

  task automatic finish_byte(input string name, input spi_byte_t tx, input spi_byte_t resp);
    logic [31:0] rd;
    rd = '0;
    while (rd[0] !== 1'b1) begin
      bus_read(ctrl_status, rd); // poll for data_ready.
    end
    check_status(name, 2'b01, rd[1:0]);
    bus_read(data, rd);
    check_byte(name, resp, rd[7:0]);
    bus_read(ctrl_status, rd);
    check_status(name, 2'b00, rd[1:0]);
    check_byte(name, tx, card_rx);
    check_edges(name, `SD_BYTE_BITS, rise_count);
  endtask

  task automatic exchange(input string name, input spi_byte_t tx, input spi_byte_t resp);
    start_byte(tx, resp);
    finish_byte(name, tx, resp);
  endtask

  // five command bytes, then the crc byte with its end bit.
  task automatic crc7_test(input string name, input crc7_t seed);
    spi_byte_t   cmd[$];
    logic [31:0] rd;
    crc7_t       exp;
    cmd.push_back(8'h40 | spi_byte_t'($urandom_range(63)));
    repeat (4) cmd.push_back(spi_byte_t'($urandom));
    bus_write(crc7, {24'h0, seed, 1'b0});
    foreach (cmd[i]) exchange(name, cmd[i], spi_byte_t'($urandom));
    exp = crc7_ref(seed, cmd);
    bus_read(crc7, rd);
    check_crc7(name, exp, rd[7:1]);
    exchange(name, {exp, 1'b1}, 8'hff);
  endtask

  task automatic crc16_test(input string name, input logic from_miso);
    spi_byte_t   sent[$];
    spi_byte_t   got[$];
    logic [31:0] rd;
    crc16_t      exp;
    bus_write(ctrl_status, {29'h0, from_miso, 2'b11});
    bus_write(crc16, 32'h0);
    repeat (6) begin
      sent.push_back(spi_byte_t'($urandom));
      got.push_back(spi_byte_t'($urandom));
      exchange(name, sent[$], got[$]);
    end
    exp = from_miso ? crc16_ref(16'h0, got) : crc16_ref(16'h0, sent);
    bus_read(crc16, rd);
    check_crc16(name, exp, rd[15:0]);
  endtask

  initial begin
    void'($urandom(32'h42b5_5999));
    rst = 1'b1;
    stb = 1'b0;
    we = 1'b0;
    addr = ctrl_status;
    data_in = '0;
    wr_protect = 1'b0;
    card_tx = '1;
    card_rx = '0;
    rise_count = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    check_ack("ack idle", 1'b0, ack);
    bus_read(ctrl_status, rd_value);
    check_status("reset status", 2'b00, rd_value[1:0]);
    wr_protect = 1'b1;
    bus_read(ctrl_status, rd_value);
    check_status("write protect", 2'b10, rd_value[1:0]);
    wr_protect = 1'b0;
    check_status("reset pins", 2'b10, {ss_n, sclk});

    bus_write(ctrl_status, 32'd1);
    check_status("select card", 2'b00, {ss_n, sclk});
    bus_write(ctrl_status, 32'd0);
    check_status("deselect card", 2'b10, {ss_n, sclk});

    bus_write(ctrl_status, 32'd1); // selected, slow clock.
    repeat (4) exchange("slow byte", spi_byte_t'($urandom), spi_byte_t'($urandom));
    bus_write(ctrl_status, 32'd3);
    repeat (16) exchange("fast byte", spi_byte_t'($urandom), spi_byte_t'($urandom));

    crc7_test("crc7 zero seed", 7'h00);
    crc7_test("crc7 random seed", crc7_t'($urandom));
    crc16_test("crc16 from miso", 1'b1);
    crc16_test("crc16 from mosi", 1'b0);

    bus_write(ctrl_status, 32'd1);
    tx_byte = spi_byte_t'($urandom);
    resp_byte = spi_byte_t'($urandom);
    start_byte(tx_byte, resp_byte);
    repeat (200) @(posedge clk);
    #1;
    bus_write(data, {24'h0, ~tx_byte}); // lands mid transfer.
    finish_byte("write while busy", tx_byte, resp_byte);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/sd_spi_ctrl_assertions.sv */
/*
 * SD SPI shifter checks: SCLK phase lengths, idle level,
 * byte done pulse and the state right after reset.
 */
`timescale 1ns/100ps
`default_nettype none
`include "sd_spi_settings.svh"

module sd_spi_ctrl_assertions (
  input wire clk,
  input wire rst,
  input wire sclk,
  input wire mosi,
  input wire fast_clock,
  input wire idle,
  input wire byte_done
);

  localparam int fast_half = `SD_FAST_WAIT + 1;
  localparam int slow_half = `SD_SLOW_WAIT + 1;

  idle_low: assert property (@(posedge clk) disable iff (rst) idle |-> !sclk)
    else $error("sclk high while the shifter is idle");

  fast_high: assert property (@(posedge clk) disable iff (rst)
    $rose(sclk) && fast_clock |-> ##fast_half $fell(sclk))
    else $error("sclk high phase has the wrong length at fast speed");

  slow_high: assert property (@(posedge clk) disable iff (rst)
    $rose(sclk) && !fast_clock |-> ##slow_half $fell(sclk))
    else $error("sclk high phase has the wrong length at slow speed");

  // a low phase ends in a rising edge, or in idle after the settle phase.
  fast_low: assert property (@(posedge clk) disable iff (rst)
    $fell(sclk) && fast_clock |-> ##fast_half ($rose(sclk) || idle))
    else $error("sclk low phase has the wrong length at fast speed");

  slow_low: assert property (@(posedge clk) disable iff (rst)
    $fell(sclk) && !fast_clock |-> ##slow_half ($rose(sclk) || idle))
    else $error("sclk low phase has the wrong length at slow speed");

  done_pulse: assert property (@(posedge clk) disable iff (rst) byte_done |=> !byte_done)
    else $error("byte_done held for more than one cycle");

  reset_state: assert property (@(posedge clk) $fell(rst) |-> !sclk && mosi)
    else $error("sclk or mosi not at the idle level after reset");

endmodule

bind sd_spi_shifter sd_spi_ctrl_assertions shifter_checks_i (
  .clk, .rst, .sclk, .mosi, .fast_clock, .idle, .byte_done
);

`default_nettype wire

/* source/sd_spi_ctrl.sv */
/*
 * SD card controller in SPI mode: four-slot register bus around
 * the byte shifter and the CRC7 and CRC16 engines.
 */
`timescale 1ns/100ps
`default_nettype none

module sd_spi_ctrl
  import sd_spi_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            stb,
  input  wire            we,
  input  wire reg_addr_t addr,
  input  wire [31:0]     data_in,
  output logic [31:0]    data_out,
  output logic           ack,
  output logic           ss_n,
  output logic           sclk,
  output logic           mosi,
  input  wire            miso,
  input  wire            wr_protect
);

  logic      data_wr;
  logic      crc7_wr;
  logic      crc16_wr;
  logic      data_rd;
  logic      fast_clock;
  logic      crc16_from_miso;
  logic      bit_latch;
  logic      byte_done;
  logic      crc16_bit;
  spi_byte_t rx_byte;
  crc7_t     crc7_value;
  crc16_t    crc16_value;

  assign ack       = stb; // bus never waits.
  assign crc16_bit = crc16_from_miso ? miso : mosi;

  sd_reg_decode decode_i (
    .clk, .rst, .stb, .we, .addr,
    .data_in(data_in[2:0]),
    .data_wr, .crc7_wr, .crc16_wr, .data_rd,
    .fast_clock, .crc16_from_miso, .ss_n
  );

  sd_spi_shifter shifter_i (
    .clk, .rst, .data_wr,
    .data_in(data_in[7:0]),
    .fast_clock, .miso, .sclk, .mosi, .rx_byte, .bit_latch, .byte_done
  );

  // seed taken from bits 7:1, matching the read-back layout.
  sd_crc #(.crc_t(crc7_t), .poly(crc7_t'(7'h09))) crc7_i (
    .clk, .rst, .load(crc7_wr), .seed(data_in[7:1]),
    .shift_en(bit_latch), .bit_in(mosi), .crc(crc7_value)
  );

  sd_crc #(.crc_t(crc16_t), .poly(crc16_t'(16'h1021))) crc16_i (
    .clk, .rst, .load(crc16_wr), .seed(data_in[15:0]),
    .shift_en(bit_latch), .bit_in(crc16_bit), .crc(crc16_value)
  );

  sd_readback readback_i (
    .clk, .rst, .addr, .byte_done, .data_rd, .wr_protect, .rx_byte,
    .crc7(crc7_value), .crc16(crc16_value), .data_out
  );

endmodule

`default_nettype wire

/* source/sd_readback.sv */
/*
 * SD read-back: data ready flag and the bus read multiplexer.
 */
`timescale 1ns/100ps
`default_nettype none

module sd_readback
  import sd_spi_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire reg_addr_t addr,
  input  wire            byte_done,
  input  wire            data_rd,
  input  wire            wr_protect,
  input  wire spi_byte_t rx_byte,
  input  wire crc7_t     crc7,
  input  wire crc16_t    crc16,
  output logic [31:0]    data_out
);

  logic data_ready;

  // a byte finishing in the same cycle as a data read keeps the flag set.
  always_ff @(posedge clk) begin
    if (rst) begin
      data_ready <= 1'b0;
    end else if (byte_done | data_rd) begin
      data_ready <= byte_done;
    end
  end

  // slot names are qualified since the crc ports shadow them.
  always_comb begin
    case (addr)
      sd_spi_pkg::ctrl_status: data_out = {30'h0, wr_protect, data_ready};
      sd_spi_pkg::data:        data_out = {24'h0, rx_byte};
      sd_spi_pkg::crc7:        data_out = {24'h0, crc7, 1'b0}; // command byte layout.
      sd_spi_pkg::crc16:       data_out = {16'h0, crc16};
      default:                 data_out = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

/* source/sd_crc.sv */
/*
 * Bit-serial CRC register (Galois form) with seed load.
 */
`timescale 1ns/100ps
`default_nettype none

module sd_crc #(
  parameter type  crc_t = logic [6:0],
  parameter crc_t poly  = '0
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       load,
  input  wire crc_t seed,
  input  wire       shift_en,
  input  wire       bit_in,
  output crc_t      crc
);

  localparam int width = $bits(crc_t);

  logic feedback;

  assign feedback = crc[width-1] ^ bit_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc <= '0;
    end else if (load) begin
      crc <= seed; // seed wins over a bit in the same cycle.
    end else if (shift_en) begin
      crc <= (crc << 1) ^ (feedback ? poly : crc_t'(0));
    end
  end

endmodule

`default_nettype wire

/* source/sd_spi_shifter.sv */
/*
 * SD SPI shifter: full-duplex byte shift register with the SCLK
 * phase sequencer (mode 0, msb first) and the byte done pulse.
 */
`timescale 1ns/100ps
`default_nettype none
`include "sd_spi_settings.svh"

module sd_spi_shifter
  import sd_spi_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            data_wr,
  input  wire spi_byte_t data_in,
  input  wire            fast_clock,
  input  wire            miso,
  output logic           sclk,
  output logic           mosi,
  output spi_byte_t      rx_byte,
  output logic           bit_latch,
  output logic           byte_done
);

  // phases 1..16 are SCLK half periods, the last one is the settle phase.
  localparam int last_phase = 2 * `SD_BYTE_BITS + 1;
  localparam int phase_bits = $clog2(last_phase + 1);

  logic [`SD_BYTE_BITS:0]   sreg;
  logic [phase_bits-1:0]    phase;
  logic [`SD_WAIT_BITS-1:0] wait_cnt;
  logic [`SD_WAIT_BITS-1:0] wait_num;
  logic                     idle;
  logic                     expired;
  logic                     load;
  logic                     shift;

  assign idle     = (phase == '0);
  assign expired  = (wait_cnt == '0);
  assign load     = data_wr & idle; // writes while busy are dropped.
  assign wait_num = fast_clock ? `SD_WAIT_BITS'(`SD_FAST_WAIT) :
                                 `SD_WAIT_BITS'(`SD_SLOW_WAIT);

  // odd phase ending raises SCLK, even phase ending lowers it.
  assign bit_latch = expired & phase[0] & (phase != phase_bits'(last_phase));
  assign shift     = expired & ~phase[0] & ~idle;
  assign byte_done = expired & (phase == phase_bits'(last_phase));

  always_ff @(posedge clk) begin
    if (rst) begin
      sclk     <= 1'b0;
      phase    <= '0;
      wait_cnt <= '0;
    end else if (!expired) begin
      wait_cnt <= wait_cnt - 1'b1;
    end else if (idle) begin
      if (load) begin
        phase    <= phase_bits'(1);
        wait_cnt <= wait_num;
      end
    end else if (byte_done) begin
      sclk  <= 1'b0;
      phase <= '0; // wait_cnt is already zero.
    end else begin
      sclk     <= phase[0];
      phase    <= phase + 1'b1;
      wait_cnt <= wait_num; // speed can change between phases.
    end
  end

  // tx byte sits in the top bits, bit 0 holds the sampled miso.
  always_ff @(posedge clk) begin
    if (rst) begin
      sreg <= '1;
    end else if (load) begin
      sreg[`SD_BYTE_BITS:1] <= data_in;
    end else begin
      if (shift) begin
        sreg[`SD_BYTE_BITS:1] <= sreg[`SD_BYTE_BITS-1:0];
      end
      if (bit_latch) begin
        sreg[0] <= miso;
      end
    end
  end

  assign mosi    = sreg[`SD_BYTE_BITS];
  assign rx_byte = sreg[`SD_BYTE_BITS:1];

endmodule

`default_nettype wire

/* source/sd_reg_decode.sv */
/*
 * SD register decode: turns bus strobes into per-slot pulses
 * and holds the control register.
 */
`timescale 1ns/100ps
`default_nettype none

module sd_reg_decode
  import sd_spi_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            stb,
  input  wire            we,
  input  wire reg_addr_t addr,
  input  wire [2:0]      data_in,
  output logic           data_wr,
  output logic           crc7_wr,
  output logic           crc16_wr,
  output logic           data_rd,
  output logic           fast_clock,
  output logic           crc16_from_miso,
  output logic           ss_n
);

  logic bus_wr;
  logic ctrl_wr;

  assign bus_wr   = stb & we;
  assign ctrl_wr  = bus_wr & (addr == ctrl_status);
  assign data_wr  = bus_wr & (addr == data);
  assign crc7_wr  = bus_wr & (addr == crc7);
  assign crc16_wr = bus_wr & (addr == crc16);
  assign data_rd  = stb & ~we & (addr == data); // clears data_ready.

  always_ff @(posedge clk) begin
    if (rst) begin
      ss_n            <= 1'b1; // card deselected.
      fast_clock      <= 1'b0;
      crc16_from_miso <= 1'b0;
    end else if (ctrl_wr) begin
      ss_n            <= ~data_in[0];
      fast_clock      <= data_in[1];
      crc16_from_miso <= data_in[2];
    end
  end

endmodule

`default_nettype wire

/* source/sd_spi_pkg.sv */
/*
 * SD SPI controller types: register slots, serial byte and CRC remainders.
 */
`default_nettype none

package sd_spi_pkg;

  // bus register slots.
  typedef enum logic [1:0] {
    ctrl_status = 2'd0,
    data        = 2'd1,
    crc7        = 2'd2,
    crc16       = 2'd3
  } reg_addr_t;

  typedef logic [7:0] spi_byte_t;

  typedef logic [6:0] crc7_t;   // x^7 + x^3 + 1.

  typedef logic [15:0] crc16_t; // x^16 + x^12 + x^5 + 1.

endpackage

`default_nettype wire

/* include/sd_spi_settings.svh */
/*
 * SD SPI controller settings: SCLK wait counts and transfer size.
 */
`ifndef SD_SPI_SETTINGS_SVH
`define SD_SPI_SETTINGS_SVH

// SCLK half period is (wait + 1) system clocks.
`define SD_FAST_WAIT 0
`define SD_SLOW_WAIT 63

// width of the half period wait counter.
`define SD_WAIT_BITS 6

// bits per full-duplex transfer.
`define SD_BYTE_BITS 8

`endif
